// File: files.f
+incdir+common
common/daddaPkg.sv
daddaTree/daddaLayer.sv
daddaTree/daddaTree.sv
bkAdder/bkPrefixAdder.sv
design/productStage.sv
design/daddaMulTop.sv
test/tbClockGen.sv
test/tbDaddaMul.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tbDaddaMul
FILELIST := files.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) common/daddaMul_consts.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/tbDaddaMul.sv
`timescale 1ns/1ps
`default_nettype none

module tbDaddaMul;

  import daddaPkg::*;

  localparam int periodNs = 20;
  localparam int resetCycles = 10;
  localparam int settleCycles = 5;
  localparam int drainLimit = 8;
  localparam int numCorners = 6;
  localparam int numCarry = 5;
  localparam int randomPairs = 200;
  // Gap test budgets three cycles per pair against an average of two
  localparam int estCycles = resetCycles + settleCycles
    + (numCorners + numCarry) * (drainLimit + 2)
    + (randomPairs + drainLimit + 1) + (3 * randomPairs + drainLimit + 1);

  typedef struct packed {
    product_t value;
    int       due;
  } expected_t;

  logic         clk;
  logic         rstN;
  logic         inValid;
  operandPair_t operands;
  logic         outValid;
  product_t     product;

  expected_t expQ [$];
  int        cycle = 0;
  int        validSeen = 0;
  int        valueErrors = 0;
  int        protocolErrors = 0;
  string     testName = "init";

  tbClockGen #(
    .periodNs (periodNs)
  ) u_tbClockGen (
    .clk (clk)
  );

  daddaMulTop u_daddaMulTop (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .operands (operands),
    .outValid (outValid),
    .product  (product)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic checkProduct(input string name, input product_t expected,
                              input product_t actual);
    if (expected !== actual) begin
      $display("FAILED %s: product expected 0x%08h, actual 0x%08h", name, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic checkValid(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("FAILED %s: outValid expected %b, actual %b", name, expected, actual);
      valueErrors++;
    end
  endtask

  // Outputs are stable by the falling edge
  always @(negedge clk) begin : monitor
    logic expectValid;
    expectValid = (expQ.size() > 0) && (expQ[0].due == cycle);
    if (outValid === 1'b1) begin
      validSeen++;
    end
    if (outValid === 1'b1 && expQ.size() == 0) begin
      $display("%s: outValid high at cycle %0d with no product pending", testName, cycle);
      protocolErrors++;
    end else begin
      checkValid(testName, expectValid, outValid);
      if (expectValid) begin
        if (outValid === 1'b1) begin
          checkProduct(testName, expQ[0].value, product);
        end
        void'(expQ.pop_front());
      end
    end
  end

  // Rows load at the next rising edge and the product one edge later
  task automatic drivePair(input operand_t a, input operand_t b, input logic valid);
    expected_t e;
    @(negedge clk);
    operands.a <= a;
    operands.b <= b;
    inValid    <= valid;
    if (valid) begin
      e.value = product_t'(longint'(a) * longint'(b));
      e.due   = cycle + 2;
      expQ.push_back(e);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    inValid <= 1'b0;
    while (expQ.size() > 0 && waited < drainLimit) begin
      @(negedge clk);
      waited++;
    end
    if (expQ.size() > 0) begin
      $display("%s: %0d product(s) never delivered", testName, expQ.size());
      protocolErrors++;
      expQ.delete();
    end
  endtask

  task automatic testReset();
    testName = "testReset";
    repeat (resetCycles) begin
      @(negedge clk);
      checkValid(testName, 1'b0, outValid);
    end
    rstN <= 1'b1;
    repeat (settleCycles) begin
      @(negedge clk);
      checkValid(testName, 1'b0, outValid);
    end
  endtask

  task automatic testCorners();
    operand_t aList [numCorners] = '{16'h0000, 16'h0001, 16'h5A5A, 16'hFFFF, 16'hAAAA,
                                     16'h8000};
    operand_t bList [numCorners] = '{16'hFFFF, 16'h1234, 16'h0001, 16'hFFFF, 16'h5555,
                                     16'h8000};
    testName = "testCorners";
    for (int i = 0; i < numCorners; i++) begin
      drivePair(aList[i], bList[i], 1'b1);
      drain();
    end
  endtask

  task automatic testCarrySplit();
    operand_t aList [numCarry] = '{16'h00FF, 16'h0100, 16'hFFFF, 16'h7FFF, 16'h8001};
    operand_t bList [numCarry] = '{16'h0101, 16'h0100, 16'h0001, 16'h0003, 16'hFFFF};
    testName = "testCarrySplit";
    for (int i = 0; i < numCarry; i++) begin
      drivePair(aList[i], bList[i], 1'b1);
      drain();
    end
  endtask

  task automatic testBackToBack();
    testName = "testBackToBack";
    repeat (randomPairs) begin
      drivePair(operand_t'($urandom), operand_t'($urandom), 1'b1);
    end
    drain();
  endtask

  task automatic testGaps();
    int   driven;
    int   seenStart;
    logic valid;
    testName  = "testGaps";
    driven    = 0;
    seenStart = validSeen;
    while (driven < randomPairs) begin
      valid = ($urandom % 2) == 1;
      // Junk operands in the gaps as well
      drivePair(operand_t'($urandom), operand_t'($urandom), valid);
      if (valid) begin
        driven++;
      end
    end
    drain();
    if (validSeen - seenStart != randomPairs) begin
      $display("%s: saw %0d outValid cycles for %0d driven pairs", testName,
               validSeen - seenStart, randomPairs);
      protocolErrors++;
    end
  endtask

  initial begin : watchdog
    #(2 * estCycles * periodNs);
    $display("Watchdog expired after %0d cycles, run did not finish", 2 * estCycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(64));
    rstN     = 1'b0;
    inValid  = 1'b0;
    operands = '0;
    testReset();
    testCorners();
    testCarrySplit();
    testBackToBack();
    testGaps();
    $display("Errors: %0d wrong value(s), %0d protocol error(s)", valueErrors,
             protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
  parameter int periodNs = 20
) (
  output logic clk
);

  // Free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: design/daddaMulTop.sv
`timescale 1ns/1ps
`default_nettype none

module daddaMulTop (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   inValid,
  input  daddaPkg::operandPair_t operands,
  output logic                   outValid,
  output daddaPkg::product_t     product
);

  import daddaPkg::*;

  // Between the tree register and the adder stage
  reducedRows_t rows;
  logic         rowsValid;

  daddaTree u_daddaTree (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .operands  (operands),
    .rowsValid (rowsValid),
    .rows      (rows)
  );

  productStage u_productStage (
    .clk       (clk),
    .rstN      (rstN),
    .rowsValid (rowsValid),
    .rows      (rows),
    .outValid  (outValid),
    .product   (product)
  );

endmodule

`default_nettype wire

// File: design/productStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "daddaMul_consts.svh"

module productStage (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   rowsValid,
  input  daddaPkg::reducedRows_t rows,
  output logic                   outValid,
  output daddaPkg::product_t     product
);

  import daddaPkg::*;

  localparam int addWidth = `DADDA_ADD_WIDTH;

  product_t sumNext;
  logic     lowCarry;

  bkPrefixAdder #(
    .width (addWidth)
  ) u_lowAdder (
    .a    (rows.rowA[addWidth-1:0]),
    .b    (rows.rowB[addWidth-1:0]),
    .cin  (1'b0),
    .sum  (sumNext[addWidth-1:0]),
    .cout (lowCarry)
  );

  // Carry out of the top half is always zero for a 16x16 product
  bkPrefixAdder #(
    .width (addWidth)
  ) u_highAdder (
    .a    (rows.rowA[2*addWidth-1:addWidth]),
    .b    (rows.rowB[2*addWidth-1:addWidth]),
    .cin  (lowCarry),
    .sum  (sumNext[2*addWidth-1:addWidth]),
    .cout ()
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      product  <= '0;
    end else begin
      outValid <= rowsValid;
      if (rowsValid) begin
        product <= sumNext;
      end
    end
  end

endmodule

`default_nettype wire

// File: bkAdder/bkPrefixAdder.sv
`timescale 1ns/1ps
`default_nettype none

`include "daddaMul_consts.svh"

module bkPrefixAdder #(
  parameter int width = `DADDA_ADD_WIDTH
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic             cin,
  output logic [width-1:0] sum,
  output logic             cout
);

  localparam int levels = $clog2(width);

  logic [width-1:0] pBit;
  logic [width-1:0] gBit;
  logic [width-1:0] pGrp;
  logic [width-1:0] gGrp;

  assign pBit = a ^ b;
  assign gBit = a & b;

  // Group terms updated in place, level by level
  always_comb begin
    pGrp = pBit;
    gGrp = gBit;
    // Carry in folds into bit 0 generate
    gGrp[0] = gBit[0] | (pBit[0] & cin);

    // Up-sweep, spans 2, 4, 8 ... ending on bits 2^k-1
    for (int k = 1; k <= levels; k++) begin
      for (int i = 0; i < width; i++) begin
        if ((i + 1) % (1 << k) == 0) begin
          gGrp[i] = gGrp[i] | (pGrp[i] & gGrp[i - (1 << (k - 1))]);
          pGrp[i] = pGrp[i] & pGrp[i - (1 << (k - 1))];
        end
      end
    end

    // Down-sweep fills the remaining prefixes
    for (int k = levels - 1; k >= 1; k--) begin
      for (int i = 0; i < width; i++) begin
        if ((i + 1) % (1 << k) == (1 << (k - 1)) && i >= (1 << k)) begin
          gGrp[i] = gGrp[i] | (pGrp[i] & gGrp[i - (1 << (k - 1))]);
          pGrp[i] = pGrp[i] & pGrp[i - (1 << (k - 1))];
        end
      end
    end
  end

  // Carry into bit i is the prefix generate of bits below it
  assign sum  = pBit ^ {gGrp[width-2:0], cin};
  assign cout = gGrp[width-1];

endmodule

`default_nettype wire

// File: daddaTree/daddaTree.sv
`timescale 1ns/1ps
`default_nettype none

`include "daddaMul_consts.svh"

module daddaTree (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   inValid,
  input  daddaPkg::operandPair_t operands,
  output logic                   rowsValid,
  output daddaPkg::reducedRows_t rows
);

  import daddaPkg::*;

  localparam int opWidth = `DADDA_OP_WIDTH;
  localparam int prodWidth = `DADDA_PROD_WIDTH;
  localparam int numLayers = `DADDA_LAYERS;

  bitMatrix_t   stage [numLayers+1];
  reducedRows_t rowsNext;

  // Partial products, column i+j
  // Columns above opWidth-1 start at row i+j-opWidth+1, so shift them down
  always_comb begin
    stage[0] = '0;
    for (int j = 0; j < opWidth; j++) begin
      for (int i = 0; i < opWidth; i++) begin
        stage[0][i + j][(i + j < opWidth) ? j : opWidth - 1 - i] =
          operands.a[i] & operands.b[j];
      end
    end
  end

  for (genvar l = 0; l < numLayers; l++) begin : gLayer
    daddaLayer #(
      .layerIdx (l)
    ) u_daddaLayer (
      .matrixIn  (stage[l]),
      .matrixOut (stage[l+1])
    );
  end

  // Two survivors per column form the rows
  always_comb begin
    for (int c = 0; c < prodWidth; c++) begin
      rowsNext.rowA[c] = stage[numLayers][c][0];
      rowsNext.rowB[c] = stage[numLayers][c][1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rowsValid <= 1'b0;
      rows      <= '0;
    end else begin
      rowsValid <= inValid;
      if (inValid) begin
        rows <= rowsNext;
      end
    end
  end

endmodule

`default_nettype wire

// File: daddaTree/daddaLayer.sv
`timescale 1ns/1ps
`default_nettype none

`include "daddaMul_consts.svh"

module daddaLayer #(
  parameter int layerIdx = 0
) (
  input  daddaPkg::bitMatrix_t matrixIn,
  output daddaPkg::bitMatrix_t matrixOut
);

  import daddaPkg::*;

  localparam int prodWidth = `DADDA_PROD_WIDTH;
  localparam int slotWidth = `DADDA_OP_WIDTH;

  // carryIn[c] holds the carries produced in column c-1
  bitMatrix_t carryIn;

  assign carryIn[0] = '0;

  for (genvar c = 0; c < prodWidth; c++) begin : gCol
    localparam int height = columnHeight(layerIdx, c);
    localparam int reduction = columnReduction(layerIdx, c);
    localparam int numFull = reduction / 2;
    localparam int numHalf = reduction % 2;
    localparam int numSum = numFull + numHalf;
    localparam int firstHalf = 3 * numFull;
    localparam int firstPass = firstHalf + 2 * numHalf;
    localparam int numPass = height - firstPass;
    localparam int numIn = (c == 0) ? 0 : (columnReduction(layerIdx, c - 1) + 1) / 2;

    logic [slotWidth-1:0] colOut;
    logic [slotWidth-1:0] colCarry;
    logic [2:0]           trio;
    logic [1:0]           duo;

    always_comb begin
      colOut   = '0;
      colCarry = '0;
      trio     = '0;
      duo      = '0;
      // Full adders on the lowest bits
      for (int i = 0; i < numFull; i++) begin
        trio        = matrixIn[c][3*i +: 3];
        colOut[i]   = ^trio;
        colCarry[i] = (trio[0] & trio[1]) | (trio[2] & (trio[0] ^ trio[1]));
      end
      if (numHalf == 1) begin
        duo               = matrixIn[c][firstHalf +: 2];
        colOut[numFull]   = duo[0] ^ duo[1];
        colCarry[numFull] = duo[0] & duo[1];
      end
      // Untouched bits ride above the sums
      for (int i = 0; i < numPass; i++) begin
        colOut[numSum + i] = matrixIn[c][firstPass + i];
      end
      // then the carries from the column below
      for (int i = 0; i < numIn; i++) begin
        colOut[numSum + numPass + i] = carryIn[c][i];
      end
    end

    assign matrixOut[c] = colOut;

    // Top column carries fall outside the 32 bit product
    if (c < prodWidth - 1) begin : gCarry
      assign carryIn[c+1] = colCarry;
    end
  end

endmodule

`default_nettype wire

// File: common/daddaPkg.sv
`default_nettype none

`include "daddaMul_consts.svh"

package daddaPkg;

  typedef logic [`DADDA_OP_WIDTH-1:0] operand_t;

  typedef struct packed {
    operand_t a;
    operand_t b;
  } operandPair_t;

  // One slot per column, live bits packed from bit 0 upward
  typedef logic [`DADDA_PROD_WIDTH-1:0][`DADDA_OP_WIDTH-1:0] bitMatrix_t;

  typedef struct packed {
    logic [`DADDA_PROD_WIDTH-1:0] rowA;
    logic [`DADDA_PROD_WIDTH-1:0] rowB;
  } reducedRows_t;

  typedef logic [`DADDA_PROD_WIDTH-1:0] product_t;

  // Sequence 2, 3, 4, 6, 9, 13 walked from the top layer down
  function automatic int daddaTarget(int layerIdx);
    int d;
    d = 2;
    for (int k = 0; k < `DADDA_LAYERS - 1 - layerIdx; k++) begin
      d = (d * 3) / 2;
    end
    return d;
  endfunction

  // Live bits in a column before the given layer
  function automatic int columnHeight(int layerIdx, int col);
    int h [`DADDA_PROD_WIDTH];
    int cin;
    int r;
    for (int c = 0; c < `DADDA_PROD_WIDTH; c++) begin
      if (c < `DADDA_OP_WIDTH) begin
        h[c] = c + 1;
      end else begin
        h[c] = `DADDA_PROD_WIDTH - 1 - c;
      end
    end
    for (int l = 0; l < layerIdx; l++) begin
      cin = 0;
      for (int c = 0; c < `DADDA_PROD_WIDTH; c++) begin
        r = h[c] + cin - daddaTarget(l);
        if (r < 0) begin
          r = 0;
        end
        // Each FA removes two bits, each HA one
        h[c] = h[c] + cin - r;
        cin = (r + 1) / 2;
      end
    end
    return h[col];
  endfunction

  // Bits a layer must remove from a column, counting incoming carries
  function automatic int columnReduction(int layerIdx, int col);
    int cin;
    int r;
    cin = 0;
    r = 0;
    for (int c = 0; c <= col; c++) begin
      r = columnHeight(layerIdx, c) + cin - daddaTarget(layerIdx);
      if (r < 0) begin
        r = 0;
      end
      cin = (r + 1) / 2;
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: common/daddaMul_consts.svh
`ifndef DADDA_MUL_CONSTS_SVH
`define DADDA_MUL_CONSTS_SVH

// Width of each multiplier operand
`define DADDA_OP_WIDTH 16

// Product width, also the column count of the dot matrix
`define DADDA_PROD_WIDTH 32

// Reduction layers from height 16 down to 2
`define DADDA_LAYERS 6

// Each half of the final prefix adder
`define DADDA_ADD_WIDTH 16

`endif
